/* hdl/bios_collector.sv */
// bios_collector module with download tracking, byte pairing and the 64-word store
`default_nettype none

module bios_collector (
	input  wire                           clk_cpu,
	input  wire                           rst_n_i,
	input  wire                           ioctl_download_i,
	input  wire                           ioctl_wr_i,
	input  wire next186_pkg::ioctl_addr_t ioctl_addr_i,
	input  wire next186_pkg::byte_t       ioctl_data_i,
	output logic                          bios_loaded_o,
	bios_stage_if.collector               stage
);

	next186_pkg::bios_word_t store [64];
	next186_pkg::byte_t      low_byte;
	logic                    dl_d;
	logic                    byte_wr;
	logic                    word_wr;

	assign byte_wr = ioctl_download_i & ioctl_wr_i;
	// odd address completes a word
	assign word_wr = byte_wr & ioctl_addr_i[0];

	assign stage.dl_active   = ioctl_download_i;
	assign stage.dl_start    = ioctl_download_i & ~dl_d;
	assign stage.block_ready = word_wr
		& (ioctl_addr_i[5:1] == 5'(next186_pkg::STAGE_BLOCK - 1));
	assign stage.rd_word     = store[stage.rd_idx];

	always_ff @(posedge clk_cpu) begin
		if (!rst_n_i) begin
			dl_d          <= 1'b0;
			bios_loaded_o <= 1'b0;
		end else begin
			dl_d <= ioctl_download_i;
			if (dl_d & ~ioctl_download_i)
				bios_loaded_o <= 1'b1;
		end
	end

	// even byte is the low half, held until its partner arrives
	always_ff @(posedge clk_cpu) begin
		if (byte_wr & ~ioctl_addr_i[0])
			low_byte <= ioctl_data_i;
		if (word_wr)
			store[ioctl_addr_i[6:1]] <= {ioctl_data_i, low_byte};
	end

endmodule

`default_nettype wire

/* hdl/bios_feeder.sv */
// bios_feeder module driving BIOS word address, data and write flag to the CPU system
`default_nettype none

module bios_feeder (
	input  wire                           clk_cpu,
	input  wire                           rst_n_i,
	input  wire                           bios_req_i,
	output next186_pkg::bios_addr_t       bios_addr_o,
	output next186_pkg::bios_word_t       bios_data_o,
	output logic                          bios_wr_o,
	bios_stage_if.feeder                  stage
);

	logic req_d;

	// store is read at the low bits of the running address
	assign stage.rd_idx = bios_addr_o[5:0];

	always_ff @(posedge clk_cpu) begin
		if (!rst_n_i) begin
			bios_addr_o <= '0;
			bios_wr_o   <= 1'b0;
			req_d       <= 1'b0;
		end else begin
			req_d <= bios_req_i;
			// end of a request burst closes the block
			if (req_d & ~bios_req_i)
				bios_wr_o <= 1'b0;
			else if (stage.block_ready)
				bios_wr_o <= 1'b1;
			else if (stage.dl_start)
				bios_wr_o <= 1'b0;
			if (stage.dl_start)
				bios_addr_o <= '0;
			else if (stage.dl_active & bios_req_i)
				bios_addr_o <= bios_addr_o + 1'b1;
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (stage.dl_active & bios_req_i)
			bios_data_o <= stage.rd_word;
	end

endmodule

`default_nettype wire

/* hdl/bios_stage_if.sv */
// bios_stage_if interface between the BIOS byte collector and the word feeder
`default_nettype none

interface bios_stage_if;

	logic                    dl_active;
	logic                    dl_start;
	logic                    block_ready;
	next186_pkg::bios_word_t rd_word;
	next186_pkg::stage_idx_t rd_idx;

	modport collector (output dl_active, output dl_start, output block_ready,
		output rd_word, input rd_idx);

	modport feeder (input dl_active, input dl_start, input block_ready,
		input rd_word, output rd_idx);

endinterface

`default_nettype wire

/* hdl/core_config.sv */
// core_config module with option decode, system reset, fake-286 sync and UART routing
`default_nettype none

module core_config (
	input  wire                          clk_cpu,
	input  wire                          rst_n_i,
	input  wire next186_pkg::status_t    status_i,
	input  wire                          reset_button_i,
	input  wire                          bios_loaded_i,
	input  wire                          uart_rx_i,
	input  wire                          com1_tx_i,
	input  wire                          mpu_tx_i,
	output logic                         sys_reset_o,
	output next186_pkg::cpu_speed_t      cpu_speed_o,
	output next186_pkg::waitstate_t      waitstates_o,
	output logic                         fake286_o,
	output logic                         adlib_hide_o,
	output logic                         joy_swap_o,
	output logic                         uart_tx_o,
	output logic                         com1_rx_o,
	output logic                         mpu_rx_o
);

	logic fake286_r;
	logic midi;

	// option fields straight through the lookup tables
	assign cpu_speed_o  = next186_pkg::SPEED_DIV_TABLE[status_i[4:2]];
	assign waitstates_o = next186_pkg::WAIT_TABLE[status_i[6:5]];
	assign adlib_hide_o = status_i[10];
	assign joy_swap_o   = status_i[8];

	// bit 9 clear selects the MPU port
	assign midi      = ~status_i[9];
	assign uart_tx_o = midi ? mpu_tx_i : com1_tx_i;
	assign com1_rx_o = midi ? 1'b1 : uart_rx_i;
	assign mpu_rx_o  = midi ? uart_rx_i : 1'b1;

	always_ff @(posedge clk_cpu) begin
		if (!rst_n_i) begin
			sys_reset_o <= 1'b1;
			fake286_r   <= 1'b0;
			fake286_o   <= 1'b0;
		end else begin
			// held in reset until a BIOS image has arrived
			sys_reset_o <= reset_button_i | status_i[0] | ~bios_loaded_i;
			fake286_r   <= status_i[7];
			fake286_o   <= fake286_r;
		end
	end

endmodule

`default_nettype wire

/* hdl/fractional_cen.sv */
// fractional_cen module, accumulator clock enable for a rate of STEP/MODULUS per cycle
`default_nettype none

module fractional_cen #(
	parameter int STEP    = 1,
	parameter int MODULUS = 2
) (
	input  wire  clk_cpu,
	input  wire  rst_n_i,
	output logic cen_o
);

	// room for the largest sum before the wrap
	localparam int ACC_W = $clog2(MODULUS + STEP) + 1;

	logic [ACC_W-1:0] acc;
	logic [ACC_W-1:0] acc_next;

	assign acc_next = acc + ACC_W'(STEP);

	always_ff @(posedge clk_cpu) begin
		if (!rst_n_i) begin
			acc   <= '0;
			cen_o <= 1'b0;
		end else if (acc_next >= ACC_W'(MODULUS)) begin
			// keep the remainder so the average rate stays exact
			acc   <= acc_next - ACC_W'(MODULUS);
			cen_o <= 1'b1;
		end else begin
			acc   <= acc_next;
			cen_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hdl/gameport_timer.sv */
// gameport_timer module with the axis one-shots, tick prescaler and button bits
`default_nettype none

module gameport_timer (
	input  wire                           clk_cpu,
	input  wire                           rst_n_i,
	input  wire next186_pkg::cpu_speed_t  cpu_speed_i,
	input  wire                           joy_swap_i,
	input  wire next186_pkg::joy_digital_t joy_digital_0_i,
	input  wire next186_pkg::joy_digital_t joy_digital_1_i,
	input  wire next186_pkg::joy_axis_t   joy_analog_0_i,
	input  wire next186_pkg::joy_axis_t   joy_analog_1_i,
	input  wire                           gameport_wr_i,
	output next186_pkg::gameport_t        gameport_o
);

	next186_pkg::gameport_state_e state;
	next186_pkg::joy_axis_t       first_stick;
	next186_pkg::joy_axis_t       second_stick;
	logic [8:0]                   presc;
	logic [7:0]                   tick;
	logic [3:0]                   shot;
	logic [3:0]                   buttons;
	logic [7:0]                   thr [4];
	logic                         tick_en;

	assign first_stick  = joy_swap_i ? joy_analog_1_i : joy_analog_0_i;
	assign second_stick = joy_swap_i ? joy_analog_0_i : joy_analog_1_i;

	// flipping the sign bit turns a signed position into a tick count
	assign thr[0] = {~second_stick[15], second_stick[14:8]};
	assign thr[1] = {~second_stick[7], second_stick[6:0]};
	assign thr[2] = {~first_stick[15], first_stick[14:8]};
	assign thr[3] = {~first_stick[7], first_stick[6:0]};

	// fire buttons read active low
	assign buttons = joy_swap_i ? ~{joy_digital_1_i[5:4], joy_digital_0_i[5:4]}
		: ~{joy_digital_0_i[5:4], joy_digital_1_i[5:4]};

	// one tick every 16 CPU clocks at the selected speed
	assign tick_en    = (presc == {cpu_speed_i, 4'hf});
	assign gameport_o = {buttons, shot};

	always_ff @(posedge clk_cpu) begin
		if (!rst_n_i) begin
			state <= next186_pkg::gp_idle;
			presc <= '0;
			tick  <= '0;
			shot  <= '0;
		end else if (gameport_wr_i) begin
			state <= next186_pkg::gp_timing;
			presc <= '0;
			tick  <= '0;
			shot  <= 4'hf;
		end else begin
			case (state)
				next186_pkg::gp_timing: begin
					for (int i = 0; i < 4; i++) begin
						if (tick == thr[i])
							shot[i] <= 1'b0;
					end
					if (tick == 8'hff) begin
						state <= next186_pkg::gp_done;
					end else if (tick_en) begin
						presc <= '0;
						tick  <= tick + 1'b1;
					end else begin
						presc <= presc + 1'b1;
					end
				end
				// full scale reached, force every axis low
				next186_pkg::gp_done: begin
					shot  <= '0;
					state <= next186_pkg::gp_idle;
				end
				default: begin
					state <= next186_pkg::gp_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/next186_glue_top.sv */
// next186_glue_top module wiring the config, clock enables, NMI, gameport and BIOS path
`default_nettype none

module next186_glue_top #(
	parameter int CLK_MHZ    = 50,
	parameter int NMI_CYCLES = 16777215
) (
	input  wire                            clk_cpu,
	input  wire                            rst_n_i,
	input  wire next186_pkg::status_t      status_i,
	input  wire                            reset_button_i,
	input  wire                            uart_rx_i,
	input  wire                            com1_tx_i,
	input  wire                            mpu_tx_i,
	input  wire next186_pkg::joy_digital_t joy_digital_0_i,
	input  wire next186_pkg::joy_digital_t joy_digital_1_i,
	input  wire next186_pkg::joy_axis_t    joy_analog_0_i,
	input  wire next186_pkg::joy_axis_t    joy_analog_1_i,
	input  wire                            gameport_wr_i,
	input  wire                            ioctl_download_i,
	input  wire                            ioctl_wr_i,
	input  wire next186_pkg::ioctl_addr_t  ioctl_addr_i,
	input  wire next186_pkg::byte_t        ioctl_data_i,
	input  wire                            bios_req_i,
	output logic                           sys_reset_o,
	output next186_pkg::cpu_speed_t        cpu_speed_o,
	output next186_pkg::waitstate_t        waitstates_o,
	output logic                           fake286_o,
	output logic                           adlib_hide_o,
	output logic                           uart_tx_o,
	output logic                           com1_rx_o,
	output logic                           mpu_rx_o,
	output logic                           cen_opl2_o,
	output logic                           cen_44100_o,
	output logic                           nmi_o,
	output next186_pkg::gameport_t         gameport_o,
	output next186_pkg::bios_addr_t        bios_addr_o,
	output next186_pkg::bios_word_t        bios_data_o,
	output logic                           bios_wr_o
);

	logic bios_loaded;
	logic joy_swap;

	bios_stage_if stage_bus ();

	core_config i_core_config (
		.clk_cpu        (clk_cpu),
		.rst_n_i        (rst_n_i),
		.status_i       (status_i),
		.reset_button_i (reset_button_i),
		.bios_loaded_i  (bios_loaded),
		.uart_rx_i      (uart_rx_i),
		.com1_tx_i      (com1_tx_i),
		.mpu_tx_i       (mpu_tx_i),
		.sys_reset_o    (sys_reset_o),
		.cpu_speed_o    (cpu_speed_o),
		.waitstates_o   (waitstates_o),
		.fake286_o      (fake286_o),
		.adlib_hide_o   (adlib_hide_o),
		.joy_swap_o     (joy_swap),
		.uart_tx_o      (uart_tx_o),
		.com1_rx_o      (com1_rx_o),
		.mpu_rx_o       (mpu_rx_o)
	);

	// about 3.58 MHz for the OPL2
	fractional_cen #(
		.STEP    (next186_pkg::OPL2_STEP),
		.MODULUS (CLK_MHZ * 100)
	) i_cen_opl2 (
		.clk_cpu (clk_cpu),
		.rst_n_i (rst_n_i),
		.cen_o   (cen_opl2_o)
	);

	fractional_cen #(
		.STEP    (next186_pkg::AUDIO_RATE),
		.MODULUS (CLK_MHZ * 1000000)
	) i_cen_44100 (
		.clk_cpu (clk_cpu),
		.rst_n_i (rst_n_i),
		.cen_o   (cen_44100_o)
	);

	nmi_pulse #(
		.NMI_CYCLES (NMI_CYCLES)
	) i_nmi_pulse (
		.clk_cpu      (clk_cpu),
		.rst_n_i      (rst_n_i),
		.nmi_button_i (status_i[1]),
		.nmi_o        (nmi_o)
	);

	gameport_timer i_gameport_timer (
		.clk_cpu         (clk_cpu),
		.rst_n_i         (rst_n_i),
		.cpu_speed_i     (cpu_speed_o),
		.joy_swap_i      (joy_swap),
		.joy_digital_0_i (joy_digital_0_i),
		.joy_digital_1_i (joy_digital_1_i),
		.joy_analog_0_i  (joy_analog_0_i),
		.joy_analog_1_i  (joy_analog_1_i),
		.gameport_wr_i   (gameport_wr_i),
		.gameport_o      (gameport_o)
	);

	bios_collector i_bios_collector (
		.clk_cpu          (clk_cpu),
		.rst_n_i          (rst_n_i),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.bios_loaded_o    (bios_loaded),
		.stage            (stage_bus.collector)
	);

	bios_feeder i_bios_feeder (
		.clk_cpu     (clk_cpu),
		.rst_n_i     (rst_n_i),
		.bios_req_i  (bios_req_i),
		.bios_addr_o (bios_addr_o),
		.bios_data_o (bios_data_o),
		.bios_wr_o   (bios_wr_o),
		.stage       (stage_bus.feeder)
	);

endmodule

`default_nettype wire

/* hdl/next186_pkg.sv */
// widths, option types, lookup tables, rate constants and the gameport state type
`default_nettype none

package next186_pkg;

	// menu option word and the settings decoded from it
	typedef logic [10:0] status_t;
	typedef logic [4:0]  cpu_speed_t;
	typedef logic [7:0]  waitstate_t;

	// download side
	typedef logic [24:0] ioctl_addr_t;
	typedef logic [7:0]  byte_t;

	// BIOS words toward the CPU system
	typedef logic [15:0] bios_word_t;
	typedef logic [13:0] bios_addr_t;
	typedef logic [5:0]  stage_idx_t;

	// joysticks and gameport
	typedef logic [15:0] joy_axis_t;
	typedef logic [7:0]  joy_digital_t;
	typedef logic [7:0]  gameport_t;

	// menu speed code to clock divider code
	localparam cpu_speed_t SPEED_DIV_TABLE [8] = '{
		5'd0, 5'd1, 5'd2, 5'd3, 5'd7, 5'd15, 5'd31, 5'd0
	};

	// ISA wait code to CPU cycles, roughly 1, 2, 3 and 4 us
	localparam waitstate_t WAIT_TABLE [4] = '{8'd50, 8'd100, 8'd166, 8'd200};

	// OPL2 enable is 3.58 MHz, expressed in units of 10 kHz
	localparam int OPL2_STEP   = 358;
	localparam int AUDIO_RATE  = 44100;
	localparam int STAGE_BLOCK = 32;

	typedef enum logic [1:0] {
		gp_idle,
		gp_timing,
		gp_done
	} gameport_state_e;

endpackage

`default_nettype wire

/* hdl/nmi_pulse.sv */
// nmi_pulse module, stretches a button edge into an NMI pulse of NMI_CYCLES cycles
`default_nettype none

module nmi_pulse #(
	parameter int NMI_CYCLES = 16777215
) (
	input  wire  clk_cpu,
	input  wire  rst_n_i,
	input  wire  nmi_button_i,
	output logic nmi_o
);

	localparam int CNT_W = $clog2(NMI_CYCLES + 1);

	logic [CNT_W-1:0] cnt;
	logic             btn_r;
	logic             btn_d;

	assign nmi_o = (cnt != '0);

	always_ff @(posedge clk_cpu) begin
		if (!rst_n_i) begin
			cnt   <= '0;
			btn_r <= 1'b0;
			btn_d <= 1'b0;
		end else begin
			btn_r <= nmi_button_i;
			btn_d <= btn_r;
			// new edges only count once the running pulse is over
			if (cnt != '0)
				cnt <= cnt - 1'b1;
			else if (btn_r & ~btn_d)
				cnt <= CNT_W'(NMI_CYCLES);
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_next186_glue \
	--Mdir obj_dir \
	-f sources.f || { echo "result: build failed"; exit 1; }

sim_out="$(./obj_dir/Vtb_next186_glue 2>&1)"
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx "SIMULATION PASSED" && echo "result: pass" ||
	{ echo "result: fail"; exit 1; }

/* sim/next186_glue_properties.sv */
// next186_glue_properties module with NMI width, OPL2 enable and BIOS write assertions, and its bind
`default_nettype none

module next186_glue_properties #(
	parameter int NMI_CYCLES = 16777215
) (
	input wire clk_cpu,
	input wire rst_n_i,
	input wire nmi_i,
	input wire cen_opl2_i,
	input wire bios_wr_i,
	input wire ioctl_download_i
);

	// cycles the NMI line has been high so far
	int high_len;

	always_ff @(posedge clk_cpu) begin
		if (!rst_n_i)
			high_len <= 0;
		else if (nmi_i)
			high_len <= high_len + 1;
		else
			high_len <= 0;
	end

	assert property (@(posedge clk_cpu) disable iff (!rst_n_i)
		nmi_i |-> high_len < NMI_CYCLES)
		else $error("nmi_o stayed high longer than NMI_CYCLES");

	assert property (@(posedge clk_cpu) disable iff (!rst_n_i)
		$fell(nmi_i) |-> high_len == NMI_CYCLES)
		else $error("nmi_o pulse ended before NMI_CYCLES");

	// OPL2 rate is well below half the clock
	assert property (@(posedge clk_cpu) disable iff (!rst_n_i)
		cen_opl2_i |=> !cen_opl2_i)
		else $error("cen_opl2_o high in two consecutive cycles");

	assert property (@(posedge clk_cpu) disable iff (!rst_n_i)
		$rose(bios_wr_i) |-> ioctl_download_i)
		else $error("bios_wr_o rose outside a download");

endmodule

bind next186_glue_top next186_glue_properties #(
	.NMI_CYCLES (NMI_CYCLES)
) i_properties (
	.clk_cpu          (clk_cpu),
	.rst_n_i          (rst_n_i),
	.nmi_i            (nmi_o),
	.cen_opl2_i       (cen_opl2_o),
	.bios_wr_i        (bios_wr_o),
	.ioctl_download_i (ioctl_download_i)
);

`default_nettype wire

/* sim/tb_next186_glue.sv */
// tb_next186_glue testbench with clock, reset, directed tests, compare tasks and cycle timeout
`default_nettype none

module tb_next186_glue;

	localparam int CLK_MHZ    = 50;
	localparam int NMI_LEN    = 64;
	localparam int CEN_WINDOW = 12000;
	// about twice the ~21000 cycles of reset, enable window, gameport passes and download
	localparam int MAX_CYCLES = 40000;

	logic                      clk_cpu;
	logic                      rst_n_i;
	next186_pkg::status_t      status_i;
	logic                      reset_button_i;
	logic                      uart_rx_i;
	logic                      com1_tx_i;
	logic                      mpu_tx_i;
	next186_pkg::joy_digital_t joy_digital_0_i;
	next186_pkg::joy_digital_t joy_digital_1_i;
	next186_pkg::joy_axis_t    joy_analog_0_i;
	next186_pkg::joy_axis_t    joy_analog_1_i;
	logic                      gameport_wr_i;
	logic                      ioctl_download_i;
	logic                      ioctl_wr_i;
	next186_pkg::ioctl_addr_t  ioctl_addr_i;
	next186_pkg::byte_t        ioctl_data_i;
	logic                      bios_req_i;
	logic                      sys_reset_o;
	next186_pkg::cpu_speed_t   cpu_speed_o;
	next186_pkg::waitstate_t   waitstates_o;
	logic                      fake286_o;
	logic                      adlib_hide_o;
	logic                      uart_tx_o;
	logic                      com1_rx_o;
	logic                      mpu_rx_o;
	logic                      cen_opl2_o;
	logic                      cen_44100_o;
	logic                      nmi_o;
	next186_pkg::gameport_t    gameport_o;
	next186_pkg::bios_addr_t   bios_addr_o;
	next186_pkg::bios_word_t   bios_data_o;
	logic                      bios_wr_o;

	int errors;
	int checks;
	int seed;
	int cycle_count;

	next186_glue_top #(
		.CLK_MHZ    (CLK_MHZ),
		.NMI_CYCLES (NMI_LEN)
	) i_dut (.*);

	initial begin
		clk_cpu = 1'b0;
		forever #20 clk_cpu = ~clk_cpu;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk_cpu);
			cycle_count++;
		end
		$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	task automatic check_bit(input logic actual, input logic expected, input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error at %0t: %s, got %b, expected %b", $time, what, actual, expected);
		end
	endtask

	task automatic check_speed(input next186_pkg::cpu_speed_t actual,
		input next186_pkg::cpu_speed_t expected, input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	task automatic check_wait(input next186_pkg::waitstate_t actual,
		input next186_pkg::waitstate_t expected, input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	task automatic check_gameport(input next186_pkg::gameport_t actual,
		input next186_pkg::gameport_t expected, input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error at %0t: %s, got %b, expected %b", $time, what, actual, expected);
		end
	endtask

	task automatic check_word(input next186_pkg::bios_word_t actual,
		input next186_pkg::bios_word_t expected, input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic check_addr(input next186_pkg::bios_addr_t actual,
		input next186_pkg::bios_addr_t expected, input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	task automatic report_test(input string name, input int start);
		$display("test %s finished with %0d errors", name, errors - start);
	endtask

	// menu speed code to divider code
	function automatic next186_pkg::cpu_speed_t expected_divider(input int code);
		case (code)
			1: return 5'd1;
			2: return 5'd2;
			3: return 5'd3;
			4: return 5'd7;
			5: return 5'd15;
			6: return 5'd31;
			default: return 5'd0;
		endcase
	endfunction

	function automatic next186_pkg::waitstate_t expected_wait(input int code);
		case (code)
			0: return 8'd50;
			1: return 8'd100;
			2: return 8'd166;
			default: return 8'd200;
		endcase
	endfunction

	// signed stick position to the tick count that ends its one-shot
	function automatic int axis_ticks(input next186_pkg::byte_t pos);
		return int'(pos ^ 8'h80);
	endfunction

	task automatic test_options_reset();
		int start;
		int code;
		start = errors;
		check_bit(sys_reset_o, 1'b1, "sys_reset_o before any download");
		for (code = 0; code < 8; code++) begin
			status_i[4:2] = 3'(code);
			status_i[6:5] = 2'(code);
			@(negedge clk_cpu);
			check_speed(cpu_speed_o, expected_divider(code), "cpu_speed_o");
			check_wait(waitstates_o, expected_wait(code % 4), "waitstates_o");
		end
		status_i[7] = 1'b1;
		@(negedge clk_cpu);
		check_bit(fake286_o, 1'b0, "fake286_o one cycle after its bit");
		@(negedge clk_cpu);
		check_bit(fake286_o, 1'b1, "fake286_o two cycles after its bit");
		status_i[7] = 1'b0;
		status_i[10] = 1'b1;
		@(negedge clk_cpu);
		check_bit(adlib_hide_o, 1'b1, "adlib_hide_o set");
		status_i[10] = 1'b0;
		@(negedge clk_cpu);
		check_bit(adlib_hide_o, 1'b0, "adlib_hide_o clear");
		// an empty download already marks the BIOS as loaded
		ioctl_download_i = 1'b1;
		@(negedge clk_cpu);
		ioctl_download_i = 1'b0;
		@(negedge clk_cpu);
		check_bit(sys_reset_o, 1'b1, "sys_reset_o as the download ends");
		@(negedge clk_cpu);
		check_bit(sys_reset_o, 1'b0, "sys_reset_o after the download");
		reset_button_i = 1'b1;
		@(negedge clk_cpu);
		check_bit(sys_reset_o, 1'b1, "sys_reset_o with the reset button");
		reset_button_i = 1'b0;
		status_i[0] = 1'b1;
		@(negedge clk_cpu);
		check_bit(sys_reset_o, 1'b1, "sys_reset_o with status bit 0");
		status_i[0] = 1'b0;
		@(negedge clk_cpu);
		check_bit(sys_reset_o, 1'b0, "sys_reset_o released");
		report_test("options_reset", start);
	endtask

	task automatic test_uart();
		int start;
		int k;
		start = errors;
		for (k = 0; k < 8; k++) begin
			status_i[9] = k[2];
			uart_rx_i = k[0];
			mpu_tx_i = k[1];
			com1_tx_i = ~k[1];
			@(negedge clk_cpu);
			if (k[2]) begin
				check_bit(com1_rx_o, k[0], "com1_rx_o in COM1 mode");
				check_bit(mpu_rx_o, 1'b1, "mpu_rx_o idle in COM1 mode");
				check_bit(uart_tx_o, ~k[1], "uart_tx_o in COM1 mode");
			end else begin
				check_bit(mpu_rx_o, k[0], "mpu_rx_o in MIDI mode");
				check_bit(com1_rx_o, 1'b1, "com1_rx_o idle in MIDI mode");
				check_bit(uart_tx_o, k[1], "uart_tx_o in MIDI mode");
			end
		end
		report_test("uart", start);
	endtask

	task automatic test_clock_enables();
		int     start;
		int     n;
		int     opl2;
		int     audio;
		longint diff;
		start = errors;
		opl2 = 0;
		audio = 0;
		for (n = 0; n < CEN_WINDOW; n++) begin
			@(negedge clk_cpu);
			if (cen_opl2_o)
				opl2++;
			if (cen_44100_o)
				audio++;
		end
		// count times divisor against window times step, allowed off by one pulse
		diff = longint'(opl2) * (CLK_MHZ * 100) - longint'(CEN_WINDOW) * 358;
		check_bit(diff <= CLK_MHZ * 100 && diff >= -(CLK_MHZ * 100), 1'b1,
			$sformatf("cen_opl2_o pulse count %0d", opl2));
		diff = longint'(audio) * (CLK_MHZ * 1000000) - longint'(CEN_WINDOW) * 44100;
		check_bit(diff <= CLK_MHZ * 1000000 && diff >= -(CLK_MHZ * 1000000), 1'b1,
			$sformatf("cen_44100_o pulse count %0d", audio));
		report_test("clock_enables", start);
	endtask

	task automatic test_nmi();
		int start;
		int lat;
		int width;
		start = errors;
		status_i[1] = 1'b1;
		lat = 0;
		while (!nmi_o && lat < 10) begin
			@(negedge clk_cpu);
			lat++;
		end
		if (!nmi_o) begin
			errors++;
			$display("nmi_o did not rise within 10 cycles of the status edge");
		end else begin
			check_bit(lat == 2, 1'b1, $sformatf("nmi_o rose %0d cycles after the edge", lat));
			width = 0;
			while (nmi_o && width < 4 * NMI_LEN) begin
				width++;
				// second edge inside the pulse
				if (width == 5)
					status_i[1] = 1'b0;
				if (width == 10)
					status_i[1] = 1'b1;
				@(negedge clk_cpu);
			end
			check_bit(width == NMI_LEN, 1'b1, $sformatf("nmi_o pulse of %0d cycles", width));
			repeat (8) @(negedge clk_cpu);
			check_bit(nmi_o, 1'b0, "nmi_o after the pulse");
		end
		status_i[1] = 1'b0;
		report_test("nmi", start);
	endtask

	task automatic gameport_pass(input logic swap);
		next186_pkg::joy_axis_t first;
		next186_pkg::joy_axis_t second;
		next186_pkg::gameport_t btn;
		next186_pkg::gameport_t bit_mask;
		int                     ticks [4];
		int                     n;
		int                     i;
		first  = swap ? joy_analog_1_i : joy_analog_0_i;
		second = swap ? joy_analog_0_i : joy_analog_1_i;
		btn = swap ? {~joy_digital_1_i[5:4], ~joy_digital_0_i[5:4], 4'h0}
			: {~joy_digital_0_i[5:4], ~joy_digital_1_i[5:4], 4'h0};
		ticks[0] = axis_ticks(second[15:8]);
		ticks[1] = axis_ticks(second[7:0]);
		ticks[2] = axis_ticks(first[15:8]);
		ticks[3] = axis_ticks(first[7:0]);
		// speed code 0, so one tick every 16 cycles
		status_i = '0;
		status_i[8] = swap;
		gameport_wr_i = 1'b1;
		for (n = 1; n <= 16 * 256 + 4; n++) begin
			@(negedge clk_cpu);
			gameport_wr_i = 1'b0;
			for (i = 0; i < 4; i++) begin
				bit_mask = next186_pkg::gameport_t'(1 << i);
				if (n == 16 * ticks[i])
					check_gameport(gameport_o & (8'hf0 | bit_mask), btn | bit_mask,
						$sformatf("gameport bit %0d before tick %0d", i, ticks[i]));
				if (n == 16 * (ticks[i] + 1) + 4)
					check_gameport(gameport_o & (8'hf0 | bit_mask), btn,
						$sformatf("gameport bit %0d after tick %0d", i, ticks[i]));
			end
		end
		check_gameport(gameport_o, btn, "gameport_o after full scale");
	endtask

	task automatic test_gameport();
		int start;
		start = errors;
		joy_analog_0_i = 16'h10f0;
		joy_analog_1_i = 16'h857f;
		joy_digital_0_i = 8'h10;
		joy_digital_1_i = 8'h20;
		gameport_pass(1'b0);
		gameport_pass(1'b1);
		status_i[8] = 1'b0;
		report_test("gameport", start);
	endtask

	task automatic send_bytes(input next186_pkg::byte_t bytes [128]);
		int i;
		int gap;
		for (i = 0; i < 128; i++) begin
			ioctl_wr_i   = 1'b1;
			ioctl_addr_i = next186_pkg::ioctl_addr_t'(i);
			ioctl_data_i = bytes[i];
			@(negedge clk_cpu);
			ioctl_wr_i = 1'b0;
			// last word of each half
			if (i % 64 == 63)
				check_bit(bios_wr_o, 1'b1, "bios_wr_o after a full block");
			gap = 1 + (($random(seed) & 32'h7fffffff) % 3);
			repeat (gap) @(negedge clk_cpu);
		end
	endtask

	task automatic answer_blocks(input next186_pkg::bios_word_t words [64]);
		int blk;
		int j;
		int waited;
		for (blk = 0; blk < 2; blk++) begin
			waited = 0;
			while (!bios_wr_o && waited < 2000) begin
				@(negedge clk_cpu);
				waited++;
			end
			if (!bios_wr_o) begin
				errors++;
				$display("bios_wr_o never rose for block %0d of the download", blk);
			end else begin
				check_addr(bios_addr_o, next186_pkg::bios_addr_t'(blk * 32),
					"bios_addr_o at burst start");
				bios_req_i = 1'b1;
				for (j = 0; j < 32; j++) begin
					@(negedge clk_cpu);
					check_word(bios_data_o, words[blk * 32 + j],
						$sformatf("bios_data_o word %0d", blk * 32 + j));
					check_addr(bios_addr_o, next186_pkg::bios_addr_t'(blk * 32 + j + 1),
						"bios_addr_o during burst");
				end
				bios_req_i = 1'b0;
				@(negedge clk_cpu);
				check_bit(bios_wr_o, 1'b0, "bios_wr_o after the burst");
			end
		end
	endtask

	task automatic test_bios_download();
		next186_pkg::byte_t      bytes [128];
		next186_pkg::bios_word_t words [64];
		int                      start;
		int                      i;
		start = errors;
		for (i = 0; i < 128; i++)
			bytes[i] = next186_pkg::byte_t'($random(seed));
		// low byte first
		for (i = 0; i < 64; i++)
			words[i] = {bytes[2 * i + 1], bytes[2 * i]};
		ioctl_download_i = 1'b1;
		@(negedge clk_cpu);
		fork
			send_bytes(bytes);
			answer_blocks(words);
		join
		ioctl_download_i = 1'b0;
		@(negedge clk_cpu);
		check_addr(bios_addr_o, 14'd64, "bios_addr_o after the download");
		report_test("bios_download", start);
	endtask

	initial begin
		errors = 0;
		checks = 0;
		seed = 54;
		rst_n_i = 1'b0;
		status_i = '0;
		reset_button_i = 1'b0;
		uart_rx_i = 1'b1;
		com1_tx_i = 1'b1;
		mpu_tx_i = 1'b1;
		joy_digital_0_i = '0;
		joy_digital_1_i = '0;
		joy_analog_0_i = '0;
		joy_analog_1_i = '0;
		gameport_wr_i = 1'b0;
		ioctl_download_i = 1'b0;
		ioctl_wr_i = 1'b0;
		ioctl_addr_i = '0;
		ioctl_data_i = '0;
		bios_req_i = 1'b0;
		repeat (16) @(negedge clk_cpu);
		rst_n_i = 1'b1;
		@(negedge clk_cpu);
		test_options_reset();
		test_uart();
		test_clock_enables();
		test_nmi();
		test_gameport();
		test_bios_download();
		$display("all tests done, %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
hdl/next186_pkg.sv
hdl/bios_stage_if.sv
hdl/core_config.sv
hdl/fractional_cen.sv
hdl/nmi_pulse.sv
hdl/gameport_timer.sv
hdl/bios_collector.sv
hdl/bios_feeder.sv
hdl/next186_glue_top.sv
sim/next186_glue_properties.sv
sim/tb_next186_glue.sv
